// ==== hdl/common.sv ====
package common;

    // model of the emulated machine, as selected by the board configuration.
    typedef enum logic [1:0] {
        MACHINE_S48,
        MACHINE_S128,
        MACHINE_S3,
        MACHINE_PENT
    } machine_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [18:0] va_t;
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  byte_t;

    // a bank is one 8 KB slice of the SRAM, i.e. va[18:13].
    typedef logic [5:0]  bank_t;

    // a ROM page is va[16:13]; ROM images never reach above 128 KB.
    typedef logic [3:0]  rom_page_t;

    typedef logic [16:0] loader_addr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // SRAM layout by va[18:13]
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 00xxxx  ROM images, 112 KB.
    // 00111x  magic service RAM, 16 KB.
    // 01xxxx  DivMMC memory, 128 KB.
    // 10xxxx  extended RAM behind port DFFD, 128 KB.
    // 11xxxx  main RAM, 128 KB.

    // upper three bits that select the magic and screen area.
    localparam logic [2:0] REGION_MAGIC_HI = 3'b111;

    localparam rom_page_t MAGIC_ROM_PAGE = 4'd4;
    localparam rom_page_t DIV_ROM_PAGE   = 4'd5;

    // DivMMC page that is fixed at 0000-1FFF when the DivMMC is mapped.
    localparam logic [3:0] DIV_LOW_PAGE = 4'd3;

    // value seen on the data bus when nothing drives it.
    localparam byte_t FILL_BYTE = 8'hFF;

endpackage

// ==== hdl/cpu_bus.sv ====
`timescale 1ns/100ps

interface cpu_bus
    import common::*;
();

    cpu_addr_t a;
    logic      mreq;
    logic      rfsh;
    logic      rd;
    logic      wr;

    // the top level drives the Z80 qualifiers, every block only watches them.
    modport host (
        output a, mreq, rfsh, rd, wr
    );

    modport mem (
        input a, mreq, rfsh, rd, wr
    );

endinterface

// ==== hdl/memcontrol.sv ====
`timescale 1ns/100ps

module memcontrol
    import common::*;
(
    input  logic         clk28,
    input  logic         rst_n,
    cpu_bus.mem          bus,
    paging_if.ctl        pg,
    input  bank_t        bank,
    input  rom_page_t    rom_page,
    input  logic         screen_fetch,
    input  logic         snow,
    input  logic [14:0]  screen_addr,
    input  logic         div_ramwr_mask,
    input  loader_addr_t rom2ram_ram_address,
    input  logic         rom2ram_ram_wren,
    input  byte_t        rom2ram_dataout,
    input  logic         magic_dout_active,
    input  byte_t        magic_dout,
    input  logic         div_dout_active,
    input  byte_t        div_dout,
    input  logic         ports_dout_active,
    input  byte_t        ports_dout,
    output va_t          va,
    output logic         n_vrd,
    output logic         n_vwr,
    output byte_t        vd_out,
    output logic         vd_oe
);

    logic mem_cycle;
    logic rom_paged;
    logic rom_hit;
    logic romreq;
    logic ramreq;
    logic ramreq_wr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign mem_cycle = bus.mreq & ~bus.rfsh;

    // the lower 16 KB reads ROM unless DivMMC RAM or a +3 all-RAM mode covers it.
    assign rom_paged = pg.magic_map | (~pg.div_ram & pg.div_map) |
                       (~pg.div_ram & ~pg.port_dffd[4] & ~pg.port_1ffd[0]);
    assign rom_hit   = mem_cycle & ~bus.a[15] & ~bus.a[14] & rom_paged;

    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            romreq    <= 1'b0;
            ramreq    <= 1'b0;
            ramreq_wr <= 1'b0;
        end else begin
            romreq    <= rom_hit;
            ramreq    <= mem_cycle & ~rom_hit;
            ramreq_wr <= mem_cycle & ~rom_hit & bus.wr & ~div_ramwr_mask;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // SRAM address and strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        if (rom2ram_ram_wren) begin
            va = {2'b00, rom2ram_ram_address};
        end else if (screen_fetch && snow) begin
            // snow keeps the CPU low byte on the bus, as the real ULA does.
            va = {REGION_MAGIC_HI, pg.screenpage, screen_addr[14:8], bus.a[7:0]};
        end else if (screen_fetch) begin
            va = {REGION_MAGIC_HI, pg.screenpage, screen_addr};
        end else if (romreq) begin
            va = {2'b00, rom_page, bus.a[12:0]};
        end else begin
            va = {bank, bus.a[12:0]};
        end
    end

    assign n_vrd = ~((((ramreq | romreq) & bus.rd) | screen_fetch) & ~rom2ram_ram_wren);
    assign n_vwr = ~((ramreq_wr & bus.wr & ~screen_fetch) | rom2ram_ram_wren);

    // the controller only drives the data bus while the SRAM is not reading.
    assign vd_oe = n_vrd & (rom2ram_ram_wren | ~bus.wr);

    always_comb begin
        if (rom2ram_ram_wren) begin
            vd_out = rom2ram_dataout;
        end else if (magic_dout_active) begin
            vd_out = magic_dout;
        end else if (div_dout_active) begin
            vd_out = div_dout;
        end else if (ports_dout_active) begin
            vd_out = ports_dout;
        end else begin
            vd_out = FILL_BYTE;
        end
    end

endmodule

// ==== hdl/memory_subsystem.sv ====
`timescale 1ns/100ps

module memory_subsystem
    import common::*;
(
    input  logic         clk28,
    input  logic         rst_n,
    input  cpu_addr_t    a,
    input  logic         mreq,
    input  logic         rfsh,
    input  logic         rd,
    input  logic         wr,
    input  machine_t     machine,
    input  logic         magic_map,
    input  logic         screenpage,
    input  logic [2:0]   rampage128,
    input  logic         rompage128,
    input  logic [2:0]   port_1ffd,
    input  logic [4:0]   port_dffd,
    input  logic [2:0]   rampage_ext,
    input  logic         div_map,
    input  logic         div_ram,
    input  logic [3:0]   div_page,
    input  logic         screen_fetch,
    input  logic         snow,
    input  logic [14:0]  screen_addr,
    input  logic         div_ramwr_mask,
    input  loader_addr_t rom2ram_ram_address,
    input  logic         rom2ram_ram_wren,
    input  byte_t        rom2ram_dataout,
    input  logic         magic_dout_active,
    input  byte_t        magic_dout,
    input  logic         div_dout_active,
    input  byte_t        div_dout,
    input  logic         ports_dout_active,
    input  byte_t        ports_dout,
    output va_t          va,
    output logic         n_vrd,
    output logic         n_vwr,
    output byte_t        vd_out,
    output logic         vd_oe
);

    bank_t     bank;
    rom_page_t rom_page;

    cpu_bus   bus ();
    paging_if pg ();

    assign bus.a    = a;
    assign bus.mreq = mreq;
    assign bus.rfsh = rfsh;
    assign bus.rd   = rd;
    assign bus.wr   = wr;

    assign pg.machine     = machine;
    assign pg.magic_map   = magic_map;
    assign pg.screenpage  = screenpage;
    assign pg.rampage128  = rampage128;
    assign pg.rompage128  = rompage128;
    assign pg.port_1ffd   = port_1ffd;
    assign pg.port_dffd   = port_dffd;
    assign pg.rampage_ext = rampage_ext;
    assign pg.div_map     = div_map;
    assign pg.div_ram     = div_ram;
    assign pg.div_page    = div_page;

    ram_mapper i_ram_mapper (
        .clk28 (clk28),
        .rst_n (rst_n),
        .bus   (bus),
        .pg    (pg),
        .bank  (bank)
    );

    rom_mapper i_rom_mapper (
        .clk28    (clk28),
        .rst_n    (rst_n),
        .bus      (bus),
        .pg       (pg),
        .rom_page (rom_page)
    );

    memcontrol i_memcontrol (
        .clk28               (clk28),
        .rst_n               (rst_n),
        .bus                 (bus),
        .pg                  (pg),
        .bank                (bank),
        .rom_page            (rom_page),
        .screen_fetch        (screen_fetch),
        .snow                (snow),
        .screen_addr         (screen_addr),
        .div_ramwr_mask      (div_ramwr_mask),
        .rom2ram_ram_address (rom2ram_ram_address),
        .rom2ram_ram_wren    (rom2ram_ram_wren),
        .rom2ram_dataout     (rom2ram_dataout),
        .magic_dout_active   (magic_dout_active),
        .magic_dout          (magic_dout),
        .div_dout_active     (div_dout_active),
        .div_dout            (div_dout),
        .ports_dout_active   (ports_dout_active),
        .ports_dout          (ports_dout),
        .va                  (va),
        .n_vrd               (n_vrd),
        .n_vwr               (n_vwr),
        .vd_out              (vd_out),
        .vd_oe               (vd_oe)
    );

endmodule

// ==== hdl/paging_if.sv ====
`timescale 1ns/100ps

interface paging_if
    import common::*;
();

    machine_t    machine;
    logic        magic_map;
    logic        screenpage;
    logic [2:0]  rampage128;
    logic        rompage128;
    logic [2:0]  port_1ffd;
    logic [4:0]  port_dffd;
    logic [2:0]  rampage_ext;
    logic        div_map;
    logic        div_ram;
    logic [3:0]  div_page;

    modport src (
        output machine, magic_map, screenpage, rampage128, rompage128,
        output port_1ffd, port_dffd, rampage_ext, div_map, div_ram, div_page
    );

    modport ram (
        input magic_map, screenpage, rampage128, port_1ffd, port_dffd,
        input rampage_ext, div_map, div_page
    );

    modport rom (input machine, magic_map, div_map, port_1ffd, rompage128);

    modport ctl (input magic_map, div_map, div_ram, port_1ffd, port_dffd, screenpage);

endinterface

// ==== hdl/ram_mapper.sv ====
`timescale 1ns/100ps

module ram_mapper
    import common::*;
(
    input  logic   clk28,
    input  logic   rst_n,
    cpu_bus.mem    bus,
    paging_if.ram  pg,
    output bank_t  bank
);

    logic  top16k;
    logic  low16k;
    bank_t paged_bank;
    bank_t fixed_bank;
    bank_t bank_next;

    assign top16k = bus.a[15] & bus.a[14];
    assign low16k = ~bus.a[15] & ~bus.a[14];

    // paged 16 KB at C000, bit 0 of the extension picks main or extended RAM.
    assign paged_bank = {1'b1, ~pg.rampage_ext[0], pg.rampage128, bus.a[13]};

    // banks 5 and 2 sit at 4000 and 8000 in every normal mode.
    assign fixed_bank = {2'b11, bus.a[14], bus.a[15], bus.a[14], bus.a[13]};

    always_comb begin
        if (pg.magic_map && top16k) begin
            bank_next = {2'b00, REGION_MAGIC_HI, bus.a[13]};
        end else if (pg.magic_map) begin
            bank_next = {REGION_MAGIC_HI, pg.screenpage, bus.a[14:13]};
        end else if (pg.div_map && low16k && bus.a[13]) begin
            bank_next = {2'b01, pg.div_page};
        end else if (pg.div_map && low16k) begin
            bank_next = {2'b01, DIV_LOW_PAGE};
        end else if (pg.port_dffd[3] && bus.a[15]) begin
            bank_next = fixed_bank;
        end else if (pg.port_dffd[3] && bus.a[14]) begin
            // flat mode moves the paged window down to 4000.
            bank_next = paged_bank;
        end else if (!pg.port_1ffd[2] && pg.port_1ffd[0]) begin
            bank_next = {2'b11, pg.port_1ffd[1], bus.a[15], bus.a[14], bus.a[13]};
        end else if (pg.port_1ffd == 3'b101) begin
            // all-RAM mode with banks 4, 5, 6 and 3.
            bank_next = {2'b11, ~top16k, bus.a[15], bus.a[14], bus.a[13]};
        end else if (pg.port_1ffd == 3'b111) begin
            // all-RAM mode with banks 4, 7, 6 and 3.
            bank_next = {2'b11, ~top16k, bus.a[15] | bus.a[14], bus.a[14], bus.a[13]};
        end else if (top16k) begin
            bank_next = paged_bank;
        end else begin
            bank_next = fixed_bank;
        end
    end

    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            bank <= '0;
        end else begin
            bank <= bank_next;
        end
    end

endmodule

// ==== hdl/rom_mapper.sv ====
`timescale 1ns/100ps

module rom_mapper
    import common::*;
(
    input  logic      clk28,
    input  logic      rst_n,
    cpu_bus.mem       bus,
    paging_if.rom     pg,
    output rom_page_t rom_page
);

    logic      rom_hi;
    logic [2:0] img;
    rom_page_t rom_page_next;

    assign rom_hi = pg.port_1ffd[2];

    always_comb begin
        if (pg.machine == MACHINE_S3 && !(rom_hi && pg.rompage128)) begin
            img = 3'd4 + {1'b0, rom_hi, pg.rompage128};
        end else if (pg.machine == MACHINE_S48) begin
            img = 3'd3;
        end else begin
            img = {2'b00, pg.rompage128};
        end
    end

    always_comb begin
        if (pg.magic_map) begin
            rom_page_next = MAGIC_ROM_PAGE;
        end else if (pg.div_map) begin
            rom_page_next = DIV_ROM_PAGE;
        end else begin
            rom_page_next = {img, bus.a[13]};
        end
    end

    always_ff @(posedge clk28) begin
        if (!rst_n) begin
            rom_page <= '0;
        end else begin
            rom_page <= rom_page_next;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --assert -f verilog.f \
    --top-module tb_memory_subsystem -o tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed, see sim.log"
exit 1

// ==== include/map_ref.svh ====
`ifndef MAP_REF_SVH
`define MAP_REF_SVH

// the expected va[18:13] of a RAM cycle is worked out per 16 KB quarter.
function automatic bank_t bank_of(
    input cpu_addr_t  a,
    input logic       magic_map,
    input logic       screenpage,
    input logic       div_map,
    input logic [3:0] div_page,
    input logic [4:0] port_dffd,
    input logic [2:0] port_1ffd,
    input logic [2:0] rampage128,
    input logic [2:0] rampage_ext
);
    logic [1:0] q;
    logic [2:0] pg16;
    bank_t      paged;
    q     = a[15:14];
    // extended RAM sits at 10xxxx and main RAM at 11xxxx.
    paged = {(rampage_ext[0] ? 2'b10 : 2'b11), rampage128, a[13]};
    case (q)
        2'b00:   pg16 = 3'd0;
        2'b01:   pg16 = 3'd5;
        2'b10:   pg16 = 3'd2;
        default: pg16 = 3'd7;
    endcase
    if (magic_map) begin
        return (q == 2'b11) ? {2'b00, REGION_MAGIC_HI, a[13]} :
                              {REGION_MAGIC_HI, screenpage, a[14:13]};
    end
    if (div_map && q == 2'b00) begin
        return {2'b01, (a[13] ? div_page : DIV_LOW_PAGE)};
    end
    if (port_dffd[3] && q != 2'b00) begin
        return (q == 2'b01) ? paged : {2'b11, pg16, a[13]};
    end
    if (!port_1ffd[2] && port_1ffd[0]) begin
        return {2'b11, port_1ffd[1], q, a[13]};
    end
    if (port_1ffd == 3'b101 || port_1ffd == 3'b111) begin
        case (q)
            2'b00:   pg16 = 3'd4;
            2'b01:   pg16 = port_1ffd[1] ? 3'd7 : 3'd5;
            2'b10:   pg16 = 3'd6;
            default: pg16 = 3'd3;
        endcase
        return {2'b11, pg16, a[13]};
    end
    return (q == 2'b11) ? paged : {2'b11, pg16, a[13]};
endfunction

// expected ROM image page for a ROM cycle.
function automatic rom_page_t rom_page_of(
    input machine_t machine,
    input logic     a13,
    input logic     magic_map,
    input logic     div_map,
    input logic     rom_hi,
    input logic     rompage128
);
    logic [2:0] img;
    if (magic_map) begin
        return MAGIC_ROM_PAGE;
    end
    if (div_map) begin
        return DIV_ROM_PAGE;
    end
    case (machine)
        MACHINE_S48: img = 3'd3;
        MACHINE_S3: begin
            // the fourth +3 ROM is the 48K BASIC image shared with the 128K.
            case ({rom_hi, rompage128})
                2'b00:   img = 3'd4;
                2'b01:   img = 3'd5;
                2'b10:   img = 3'd6;
                default: img = 3'd1;
            endcase
        end
        default: img = rompage128 ? 3'd1 : 3'd0;
    endcase
    return {img, a13};
endfunction

`endif

// ==== testbench/tb_memory_subsystem.sv ====
`timescale 1ns/100ps

module tb_memory_subsystem
    import common::*;
();

`include "map_ref.svh"

    localparam int ROM_CYCLES    = 64;
    localparam int RAM_CYCLES    = 96;
    localparam int SCREEN_CYCLES = 24;
    localparam int LOADER_CYCLES = 24;
    localparam int DATA_CYCLES   = 32;
    localparam int TOTAL_CYCLES  = 1 + ROM_CYCLES + RAM_CYCLES + SCREEN_CYCLES +
                                   LOADER_CYCLES + DATA_CYCLES;
    // three clocks per CPU cycle, two reset clocks and some slack.
    localparam int TIMEOUT_NS    = (TOTAL_CYCLES * 3 + 4) * 20 + 1000;

    logic         clk28;
    logic         rst_n;
    cpu_addr_t    a;
    logic         mreq;
    logic         rfsh;
    logic         rd;
    logic         wr;
    machine_t     machine;
    logic         magic_map;
    logic         screenpage;
    logic [2:0]   rampage128;
    logic         rompage128;
    logic [2:0]   port_1ffd;
    logic [4:0]   port_dffd;
    logic [2:0]   rampage_ext;
    logic         div_map;
    logic         div_ram;
    logic [3:0]   div_page;
    logic         screen_fetch;
    logic         snow;
    logic [14:0]  screen_addr;
    logic         div_ramwr_mask;
    loader_addr_t rom2ram_ram_address;
    logic         rom2ram_ram_wren;
    byte_t        rom2ram_dataout;
    logic         magic_dout_active;
    byte_t        magic_dout;
    logic         div_dout_active;
    byte_t        div_dout;
    logic         ports_dout_active;
    byte_t        ports_dout;
    va_t          va;
    logic         n_vrd;
    logic         n_vwr;
    byte_t        vd_out;
    logic         vd_oe;

    // expected response of the current CPU cycle.
    logic         chk;
    va_t          exp_va;
    va_t          va_mask;
    logic [2:0]   exp_strobes;
    logic         vd_chk;
    byte_t        exp_vd;

    integer       seed;
    int           va_errors;
    int           strobe_errors;
    int           data_errors;

    memory_subsystem i_dut (.*);

    initial begin
        clk28 = 1'b0;
        forever #10 clk28 = ~clk28;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks sampled on the falling edge while the bus is stable
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assert property (@(negedge clk28) disable iff (!rst_n)
                     chk |-> ((va ^ exp_va) & va_mask) == '0)
        else begin
            va_errors++;
            $display("Error at %0d ns: va %05h, expected %05h", $time,
                     $sampled(va), $sampled(exp_va));
        end

    assert property (@(negedge clk28) disable iff (!rst_n)
                     chk |-> {n_vrd, n_vwr, vd_oe} == exp_strobes)
        else begin
            strobe_errors++;
            $display("Error at %0d ns: n_vrd/n_vwr/vd_oe %b, expected %b", $time,
                     $sampled({n_vrd, n_vwr, vd_oe}), $sampled(exp_strobes));
        end

    assert property (@(negedge clk28) disable iff (!rst_n)
                     (chk && vd_chk) |-> vd_out == exp_vd)
        else begin
            data_errors++;
            $display("Error at %0d ns: vd_out %02h, expected %02h", $time,
                     $sampled(vd_out), $sampled(exp_vd));
        end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic clear_inputs();
        a                   = '0;
        mreq                = 1'b0;
        rfsh                = 1'b0;
        rd                  = 1'b0;
        wr                  = 1'b1;
        machine             = MACHINE_S48;
        magic_map           = 1'b0;
        screenpage          = 1'b0;
        rampage128          = '0;
        rompage128          = 1'b0;
        port_1ffd           = '0;
        port_dffd           = '0;
        rampage_ext         = '0;
        div_map             = 1'b0;
        div_ram             = 1'b0;
        div_page            = '0;
        screen_fetch        = 1'b0;
        snow                = 1'b0;
        screen_addr         = '0;
        div_ramwr_mask      = 1'b0;
        rom2ram_ram_address = '0;
        rom2ram_ram_wren    = 1'b0;
        rom2ram_dataout     = '0;
        magic_dout_active   = 1'b0;
        magic_dout          = '0;
        div_dout_active     = 1'b0;
        div_dout            = '0;
        ports_dout_active   = 1'b0;
        ports_dout          = '0;
    endtask

    task automatic expect_outputs(va_t v, va_t mask, logic nrd, logic nwr, logic oe);
        exp_va      = v;
        va_mask     = mask;
        exp_strobes = {nrd, nwr, oe};
        vd_chk      = 1'b0;
    endtask

    // the cycle stays on the bus for three clocks and is checked on the last two.
    task automatic hold_and_check();
        @(negedge clk28);
        chk = 1'b1;
        repeat (2) @(negedge clk28);
        chk = 1'b0;
    endtask

    // the lower 16 KB is ROM under magic, under DivMMC without its RAM, or in normal paging.
    function automatic logic rom_access(cpu_addr_t addr);
        logic paged_in;
        paged_in = magic_map | (div_map & ~div_ram) |
                   (~div_ram & ~port_dffd[4] & ~port_1ffd[0]);
        return (addr[15:14] == 2'b00) && paged_in;
    endfunction

    task automatic rom_reads();
        rom_page_t p;
        for (int m = 0; m < 4; m++) begin
            for (int i = 0; i < ROM_CYCLES / 4; i++) begin
                clear_inputs();
                machine    = machine_t'(2'(m));
                a          = 16'($random(seed)) & 16'h3FFF;
                rompage128 = 1'($random(seed));
                port_1ffd  = {1'($random(seed)), 2'b00};
                magic_map  = (i % 8 == 5);
                div_map    = (i % 8 >= 6);
                mreq       = 1'b1;
                rd         = 1'b1;
                wr         = 1'b0;
                p = rom_page_of(machine, a[13], magic_map, div_map, port_1ffd[2], rompage128);
                expect_outputs({2'b00, p, a[12:0]}, '1, 1'b0, 1'b1, 1'b0);
                hold_and_check();
            end
        end
    endtask

    task automatic ram_cycles();
        bank_t b;
        for (int i = 0; i < RAM_CYCLES; i++) begin
            clear_inputs();
            a              = 16'($random(seed));
            magic_map      = (3'($random(seed)) == 3'd0);
            div_map        = 1'($random(seed));
            div_ram        = 1'($random(seed));
            div_page       = 4'($random(seed));
            rampage128     = 3'($random(seed));
            rampage_ext    = 3'($random(seed));
            port_dffd      = 5'($random(seed));
            port_1ffd      = 3'($random(seed));
            screenpage     = 1'($random(seed));
            div_ramwr_mask = (2'($random(seed)) == 2'b00);
            wr             = 1'($random(seed));
            rd             = ~wr;
            mreq           = 1'b1;
            if (rom_access(a)) begin
                a[14] = 1'b1;
            end
            b = bank_of(a, magic_map, screenpage, div_map, div_page, port_dffd,
                        port_1ffd, rampage128, rampage_ext);
            expect_outputs({b, a[12:0]}, '1, ~rd, ~(wr & ~div_ramwr_mask), 1'b0);
            hold_and_check();
        end
    endtask

    task automatic screen_fetches();
        va_t v;
        for (int i = 0; i < SCREEN_CYCLES; i++) begin
            clear_inputs();
            a            = 16'($random(seed)) | 16'h8000;
            screenpage   = 1'($random(seed));
            rampage128   = 3'($random(seed));
            screen_addr  = 15'($random(seed));
            snow         = 1'($random(seed));
            screen_fetch = 1'b1;
            mreq         = 1'b1;
            wr           = 1'b1;
            if (snow) begin
                v = {3'b111, screenpage, screen_addr[14:8], a[7:0]};
            end else begin
                v = {3'b111, screenpage, screen_addr};
            end
            expect_outputs(v, '1, 1'b0, 1'b1, 1'b0);
            hold_and_check();
        end
    endtask

    task automatic loader_writes();
        for (int i = 0; i < LOADER_CYCLES; i++) begin
            clear_inputs();
            a                   = 16'($random(seed));
            mreq                = 1'($random(seed));
            wr                  = 1'($random(seed));
            rd                  = ~wr;
            screen_fetch        = 1'($random(seed));
            magic_dout_active   = 1'($random(seed));
            magic_dout          = 8'($random(seed));
            rom2ram_ram_address = 17'($random(seed));
            rom2ram_dataout     = 8'($random(seed));
            rom2ram_ram_wren    = 1'b1;
            expect_outputs({2'b00, rom2ram_ram_address}, '1, 1'b1, 1'b0, 1'b1);
            vd_chk = 1'b1;
            exp_vd = rom2ram_dataout;
            hold_and_check();
        end
    endtask

    task automatic data_sources();
        for (int i = 0; i < DATA_CYCLES; i++) begin
            clear_inputs();
            a  = 16'($random(seed));
            wr = 1'b0;
            {magic_dout_active, div_dout_active, ports_dout_active} = 3'($random(seed));
            magic_dout = 8'($random(seed));
            div_dout   = 8'($random(seed));
            ports_dout = 8'($random(seed));
            expect_outputs('0, '0, 1'b1, 1'b1, 1'b1);
            vd_chk = 1'b1;
            if (magic_dout_active) begin
                exp_vd = magic_dout;
            end else if (div_dout_active) begin
                exp_vd = div_dout;
            end else if (ports_dout_active) begin
                exp_vd = ports_dout;
            end else begin
                exp_vd = 8'hFF;
            end
            hold_and_check();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        seed          = 32'h30419d66;
        va_errors     = 0;
        strobe_errors = 0;
        data_errors   = 0;
        chk           = 1'b0;
        rst_n         = 1'b0;
        clear_inputs();
        expect_outputs('0, '0, 1'b1, 1'b1, 1'b0);
        exp_vd = '0;
        repeat (2) @(posedge clk28);
        @(negedge clk28);
        rst_n = 1'b1;
        // the bus stays idle with wr high and the controller leaves the data bus alone.
        hold_and_check();
        rom_reads();
        ram_cycles();
        screen_fetches();
        loader_writes();
        data_sources();
        $display("Done: va errors %0d, strobe errors %0d, data bus errors %0d.",
                 va_errors, strobe_errors, data_errors);
        if (va_errors + strobe_errors + data_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns.", TIMEOUT_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
hdl/common.sv
hdl/cpu_bus.sv
hdl/paging_if.sv
hdl/ram_mapper.sv
hdl/rom_mapper.sv
hdl/memcontrol.sv
hdl/memory_subsystem.sv
testbench/tb_memory_subsystem.sv
